// File: src/trellis_macros.svh
// trellis host bus definitions
`ifndef TRELLIS_MACROS_SVH
`define TRELLIS_MACROS_SVH

//**************************************************************************
// version and bus address map
//**************************************************************************

`define TRELLIS_VERSION  16'h0032
`define ADDR_MSB         11        // bus words are 16 bits, so no addr bit 0

// space codes live in address bits 11:8
`define SPACE_MISC       4'd0
`define SPACE_DAC0       4'd1
`define SPACE_DAC1       4'd2
`define SPACE_DAC2       4'd3

// byte offsets inside misc space
`define MISC_VERSION     12'h002
`define MISC_RESET       12'h004

//**************************************************************************
// DAC channel configuration fields
//**************************************************************************

`define CFG_ENABLE_BIT   0         // low half
`define CFG_FORCE_BIT    1         // low half
`define CFG_CODE_LSB     16        // forced code, word bits 29:16
`define DAC_MIDSCALE     14'h2000

`define RESET_STRETCH    6         // cycles held after the last request

`endif

// File: src/trellis_pkg.sv
// trellis shared types
package trellis_pkg;

  // processor bus word
  typedef logic [15:0] bus_word_t;

  // sample from the demod side, two's complement
  typedef logic signed [17:0] dac_sample_t;

  // offset binary code on the DAC pins
  typedef logic [13:0] dac_code_t;

  // channel config register
  // the bus sees two halves, the channel datapath sees one word
  typedef union packed {
    logic [31:0] word;
    struct packed {
      bus_word_t hi;   // addr bit 1 set
      bus_word_t lo;   // addr bit 1 clear
    } half;
  } cfg_reg_u;

endpackage

// File: src/trellis_bus_decode.sv
// host bus address decode
`timescale 1ns/1ps
`include "trellis_macros.svh"

module trellis_bus_decode (
  input  logic               ncs_i,
  input  logic               nwe_i,
  input  logic               nrd_i,
  input  logic [`ADDR_MSB:1] addr_i,
  output logic [2:0]         dac_sel_o,
  output logic               wr_lo_o,
  output logic               wr_hi_o,
  output logic               sw_reset_req_o,
  output logic               rd_hi_o,
  output logic               rd_version_o,
  output logic               rd_en_o,
  output logic [3:0]         rd_space_o
);

  logic        cs;
  logic        wr_act;
  logic [3:0]  space;
  logic [11:0] misc_off;
  logic        in_misc;

  //**************************************************************************
  // strobes and space
  //**************************************************************************

  assign cs     = ~ncs_i;
  assign wr_act = cs & ~nwe_i;                  // plain level strobe
  assign space  = addr_i[`ADDR_MSB:8];

  // byte offset within the space
  assign misc_off = {4'h0, addr_i[7:1], 1'b0};  // bit 0 never on the bus
  assign in_misc  = (space == `SPACE_MISC);

  //**************************************************************************
  // write side
  //**************************************************************************

  assign dac_sel_o[0] = (space == `SPACE_DAC0);
  assign dac_sel_o[1] = (space == `SPACE_DAC1);
  assign dac_sel_o[2] = (space == `SPACE_DAC2);

  // channels qualify these half strobes with their own select
  assign wr_lo_o = wr_act & ~addr_i[1];
  assign wr_hi_o = wr_act & addr_i[1];

  // held for as long as the write lasts
  assign sw_reset_req_o = wr_act & in_misc & (misc_off == `MISC_RESET);

  //**************************************************************************
  // read side
  //**************************************************************************

  assign rd_en_o      = cs & ~nrd_i;
  assign rd_space_o   = space;
  assign rd_hi_o      = addr_i[1];
  assign rd_version_o = in_misc & (misc_off == `MISC_VERSION);

endmodule

// File: src/trellis_reset_gen.sv
// core reset stretcher
`timescale 1ns/1ps
`include "trellis_macros.svh"

module trellis_reset_gen (
  input  logic ck933,
  input  logic rs,
  input  logic sw_reset_req_i,
  output logic core_reset_o
);

  localparam int cnt_w = $clog2(`RESET_STRETCH + 1);

  logic [cnt_w-1:0] stretch_cnt;

  //**************************************************************************
  // stretch counter
  //**************************************************************************

  // reloads every cycle the request is seen, then runs down to zero
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      stretch_cnt <= '0;
    end else if (sw_reset_req_i) begin
      stretch_cnt <= cnt_w'(`RESET_STRETCH);
    end else if (stretch_cnt != '0) begin
      stretch_cnt <= stretch_cnt - cnt_w'(1);
    end
  end

  // external reset passes straight through
  assign core_reset_o = rs | (stretch_cnt != '0);

  // a request seen on an edge must hold the core in reset on the next one,
  // and the release waits for the full stretch after the request drops
  req_to_reset_a : assert property (
    @(posedge ck933) disable iff (rs)
    sw_reset_req_i |=> core_reset_o
  ) else $error("core reset missing after software reset request");

  stretch_len_a : assert property (
    @(posedge ck933) disable iff (rs)
    $fell(sw_reset_req_i) |-> core_reset_o [*`RESET_STRETCH]
  ) else $error("core reset released before the stretch ran out");

endmodule

// File: src/trellis_dac_channel.sv
// dac output channel
`timescale 1ns/1ps
`include "trellis_macros.svh"

module trellis_dac_channel (
  input  logic                     ck933,
  input  logic                     rs,
  input  logic                     core_reset_i,
  input  logic                     sel_i,
  input  logic                     wr_lo_i,
  input  logic                     wr_hi_i,
  input  logic                     sample_en_i,
  input  trellis_pkg::bus_word_t   data_i,
  input  trellis_pkg::dac_sample_t sample_i,
  output trellis_pkg::cfg_reg_u    cfg_o,
  output trellis_pkg::dac_code_t   dac_d_o
);

  import trellis_pkg::*;

  cfg_reg_u  cfg_q;
  dac_code_t code_nxt;

  //**************************************************************************
  // configuration register
  //**************************************************************************

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      cfg_q.word <= '0;
    end else if (core_reset_i) begin
      cfg_q.word <= '0;                         // software reset clears too
    end else begin
      if (sel_i && wr_lo_i) begin
        cfg_q.half.lo <= data_i;
      end
      if (sel_i && wr_hi_i) begin
        cfg_q.half.hi <= data_i;
      end
    end
  end

  assign cfg_o = cfg_q;

  //**************************************************************************
  // sample formatting
  //**************************************************************************

  always_comb begin
    if (cfg_q.word[`CFG_FORCE_BIT]) begin
      code_nxt = cfg_q.word[`CFG_CODE_LSB +: $bits(dac_code_t)];  // forced code
    end else if (cfg_q.word[`CFG_ENABLE_BIT]) begin
      // top 14 bits with the msb flipped for offset binary
      code_nxt = {~sample_i[17], sample_i[16:4]};
    end else begin
      code_nxt = `DAC_MIDSCALE;
    end
  end

  // output register
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      dac_d_o <= `DAC_MIDSCALE;
    end else if (core_reset_i) begin
      dac_d_o <= `DAC_MIDSCALE;
    end else if (sample_en_i) begin
      dac_d_o <= code_nxt;
    end
  end

  // pins sit at mid-scale when the reset generator lets go
  midscale_after_reset_a : assert property (
    @(posedge ck933) disable iff (rs)
    $fell(core_reset_i) |-> (dac_d_o == `DAC_MIDSCALE)
  ) else $error("dac output not mid-scale after reset: %h", dac_d_o);

endmodule

// File: src/trellis_read_mux.sv
// processor read data mux
`timescale 1ns/1ps
`include "trellis_macros.svh"

module trellis_read_mux (
  input  logic                   rd_en_i,
  input  logic                   rd_hi_i,
  input  logic                   rd_version_i,
  input  logic [3:0]             rd_space_i,
  input  trellis_pkg::cfg_reg_u  cfg0_i,
  input  trellis_pkg::cfg_reg_u  cfg1_i,
  input  trellis_pkg::cfg_reg_u  cfg2_i,
  output trellis_pkg::bus_word_t data_o,
  output logic                   data_oe_o
);

  import trellis_pkg::*;

  cfg_reg_u cfg_sel;
  logic     cfg_hit;

  //**************************************************************************
  // channel select
  //**************************************************************************

  always_comb begin
    cfg_sel = '0;
    cfg_hit = 1'b0;
    case (rd_space_i)
      `SPACE_DAC0: begin
        cfg_sel = cfg0_i;
        cfg_hit = 1'b1;
      end
      `SPACE_DAC1: begin
        cfg_sel = cfg1_i;
        cfg_hit = 1'b1;
      end
      `SPACE_DAC2: begin
        cfg_sel = cfg2_i;
        cfg_hit = 1'b1;
      end
      default: begin
        cfg_hit = 1'b0;                         // misc or unmapped
      end
    endcase
  end

  //**************************************************************************
  // output word
  //**************************************************************************

  always_comb begin
    if (rd_version_i) begin
      data_o = `TRELLIS_VERSION;
    end else if (cfg_hit) begin
      data_o = rd_hi_i ? cfg_sel.half.hi : cfg_sel.half.lo;
    end else begin
      data_o = '0;                              // unmapped reads as zero
    end
  end

  assign data_oe_o = rd_en_i;                   // drive the pads only on reads

endmodule

// File: src/trellis_top.sv
// trellis host bus and dac top level
`timescale 1ns/1ps
`include "trellis_macros.svh"

module trellis_top (
  input  logic                     ck933,
  input  logic                     rs,
  input  logic                     ncs_i,
  input  logic                     nwe_i,
  input  logic                     nrd_i,
  input  logic [`ADDR_MSB:1]       addr_i,
  input  trellis_pkg::bus_word_t   data_i,
  input  logic                     sample0_en_i,
  input  logic                     sample1_en_i,
  input  logic                     sample2_en_i,
  input  trellis_pkg::dac_sample_t sample0_i,
  input  trellis_pkg::dac_sample_t sample1_i,
  input  trellis_pkg::dac_sample_t sample2_i,
  output trellis_pkg::bus_word_t   data_o,
  output logic                     data_oe_o,
  output trellis_pkg::dac_code_t   dac0_d_o,
  output trellis_pkg::dac_code_t   dac1_d_o,
  output trellis_pkg::dac_code_t   dac2_d_o,
  output logic                     dac_rst_o
);

  import trellis_pkg::*;

  logic       wr_lo;
  logic       wr_hi;
  logic       sw_reset_req;
  logic       core_reset;
  logic [2:0] dac_sel;
  logic       rd_en;
  logic       rd_hi;
  logic       rd_version;
  logic [3:0] rd_space;
  cfg_reg_u   cfg0;
  cfg_reg_u   cfg1;
  cfg_reg_u   cfg2;

  //**************************************************************************
  // bus decode and reset
  //**************************************************************************

  trellis_bus_decode u_bus_decode (
    .ncs_i          (ncs_i),
    .nwe_i          (nwe_i),
    .nrd_i          (nrd_i),
    .addr_i         (addr_i),
    .dac_sel_o      (dac_sel),
    .wr_lo_o        (wr_lo),
    .wr_hi_o        (wr_hi),
    .sw_reset_req_o (sw_reset_req),
    .rd_hi_o        (rd_hi),
    .rd_version_o   (rd_version),
    .rd_en_o        (rd_en),
    .rd_space_o     (rd_space)
  );

  trellis_reset_gen u_reset_gen (
    .ck933          (ck933),
    .rs             (rs),
    .sw_reset_req_i (sw_reset_req),
    .core_reset_o   (core_reset)
  );

  assign dac_rst_o = core_reset;                // DAC chip follows the core

  //**************************************************************************
  // dac channels
  //**************************************************************************

  trellis_dac_channel u_dac0 (
    .ck933 (ck933), .rs (rs), .core_reset_i (core_reset),
    .sel_i (dac_sel[0]), .wr_lo_i (wr_lo), .wr_hi_i (wr_hi),
    .sample_en_i (sample0_en_i), .data_i (data_i), .sample_i (sample0_i),
    .cfg_o (cfg0), .dac_d_o (dac0_d_o)
  );

  trellis_dac_channel u_dac1 (
    .ck933 (ck933), .rs (rs), .core_reset_i (core_reset),
    .sel_i (dac_sel[1]), .wr_lo_i (wr_lo), .wr_hi_i (wr_hi),
    .sample_en_i (sample1_en_i), .data_i (data_i), .sample_i (sample1_i),
    .cfg_o (cfg1), .dac_d_o (dac1_d_o)
  );

  trellis_dac_channel u_dac2 (
    .ck933 (ck933), .rs (rs), .core_reset_i (core_reset),
    .sel_i (dac_sel[2]), .wr_lo_i (wr_lo), .wr_hi_i (wr_hi),
    .sample_en_i (sample2_en_i), .data_i (data_i), .sample_i (sample2_i),
    .cfg_o (cfg2), .dac_d_o (dac2_d_o)
  );

  //**************************************************************************
  // read back
  //**************************************************************************

  trellis_read_mux u_read_mux (
    .rd_en_i      (rd_en),
    .rd_hi_i      (rd_hi),
    .rd_version_i (rd_version),
    .rd_space_i   (rd_space),
    .cfg0_i       (cfg0),
    .cfg1_i       (cfg1),
    .cfg2_i       (cfg2),
    .data_o       (data_o),
    .data_oe_o    (data_oe_o)
  );

endmodule

// File: verif/trellis_clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ps

module trellis_clk_gen #(
  parameter int half_period  = 20,              // ns, 40 ns clock
  parameter int reset_cycles = 4
) (
  output logic ck933,
  output logic rs
);

  initial begin
    ck933 = 1'b0;
    forever #(half_period) ck933 = ~ck933;
  end

  // release on a falling edge, clear of the active edge
  initial begin
    rs = 1'b1;
    repeat (reset_cycles) @(posedge ck933);
    @(negedge ck933);
    rs = 1'b0;
  end

endmodule

// File: verif/trellis_tb.sv
// trellis host bus and dac testbench
`timescale 1ns/1ps
`include "trellis_macros.svh"

module trellis_tb;

  import trellis_pkg::*;

  localparam int wait_limit = 40;               // cycles per wait

  logic               ck933;
  logic               rs;
  logic               ncs;
  logic               nwe;
  logic               nrd;
  logic [`ADDR_MSB:1] addr;
  bus_word_t          data_in;
  bus_word_t          data_out;
  logic               data_oe;
  logic [2:0]         smp_en;
  dac_sample_t [2:0]  smp;
  dac_code_t [2:0]    dac_d;
  logic               dac_rst;

  cfg_reg_u    cfg_model [3];                   // last words written by the bus
  dac_code_t   exp_code [3];
  logic        model_clear;                     // software reset in progress
  logic        dac_check_on;
  logic [31:0] rng;
  bus_word_t   rd_val;

  trellis_clk_gen u_clk_gen (.ck933 (ck933), .rs (rs));

  trellis_top u_trellis_top (
    .ck933 (ck933), .rs (rs),
    .ncs_i (ncs), .nwe_i (nwe), .nrd_i (nrd), .addr_i (addr), .data_i (data_in),
    .sample0_en_i (smp_en[0]), .sample1_en_i (smp_en[1]), .sample2_en_i (smp_en[2]),
    .sample0_i (smp[0]), .sample1_i (smp[1]), .sample2_i (smp[2]),
    .data_o (data_out), .data_oe_o (data_oe),
    .dac0_d_o (dac_d[0]), .dac1_d_o (dac_d[1]), .dac2_d_o (dac_d[2]),
    .dac_rst_o (dac_rst)
  );

  //**************************************************************************
  // reference model
  //**************************************************************************

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // offset binary is the signed sample moved up by half scale
  function automatic dac_code_t ref_dac_code(input dac_sample_t s, input cfg_reg_u c);
    logic [17:0] biased;
    biased = s + 18'h20000;
    if (c.half.lo[`CFG_FORCE_BIT]) begin
      return c.half.hi[13:0];
    end
    if (c.half.lo[`CFG_ENABLE_BIT]) begin
      return biased[17:4];                      // keep the 14 top bits
    end
    return `DAC_MIDSCALE;
  endfunction

  function automatic logic [11:0] cfg_addr(input int ch, input logic hi);
    return {4'(`SPACE_DAC0 + ch), 6'h00, hi, 1'b0};
  endfunction

  // expected pin codes, one register stage like the channel
  always @(posedge ck933) begin : dac_model
    for (int ch = 0; ch < 3; ch++) begin
      if (rs || model_clear) begin
        exp_code[ch] = `DAC_MIDSCALE;
      end else if (smp_en[ch]) begin
        exp_code[ch] = ref_dac_code(smp[ch], cfg_model[ch]);
      end
    end
  end

  //**************************************************************************
  // checks
  //**************************************************************************

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_code(input string name, input dac_code_t got, input dac_code_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  // outputs are registered, so the falling edge sees settled values
  always @(negedge ck933) begin : dac_compare
    if (dac_check_on) begin
      for (int ch = 0; ch < 3; ch++) begin
        check_code($sformatf("dac%0d_d_o", ch), dac_d[ch], exp_code[ch]);
      end
    end
  end

  task automatic check_dac_midscale();
    for (int ch = 0; ch < 3; ch++) begin
      check_code($sformatf("dac%0d_d_o", ch), dac_d[ch], `DAC_MIDSCALE);
    end
  endtask

  //**************************************************************************
  // bus and sample stimulus
  //**************************************************************************

  task automatic bus_write(input logic [11:0] byte_addr, input bus_word_t value);
    @(negedge ck933);
    addr    = byte_addr[11:1];
    data_in = value;
    ncs     = 1'b0;
    nwe     = 1'b0;
    @(negedge ck933);                           // one rising edge with the strobe
    ncs = 1'b1;
    nwe = 1'b1;
  endtask

  task automatic bus_read(input logic [11:0] byte_addr, output bus_word_t value);
    @(negedge ck933);
    addr = byte_addr[11:1];
    ncs  = 1'b0;
    nrd  = 1'b0;
    @(posedge ck933);
    value = data_out;
    check_flag("data_oe_o", data_oe, 1'b1);
    @(negedge ck933);
    ncs = 1'b1;
    nrd = 1'b1;
  endtask

  task automatic expect_read(input logic [11:0] byte_addr, input bus_word_t exp,
                             input string name);
    bus_read(byte_addr, rd_val);
    check_word(name, rd_val, exp);
  endtask

  task automatic cfg_write(input int ch, input logic hi, input bus_word_t value);
    bus_write(cfg_addr(ch, hi), value);
    if (hi) begin
      cfg_model[ch].half.hi = value;
    end else begin
      cfg_model[ch].half.lo = value;
    end
  endtask

  task automatic check_cfg_all();
    for (int ch = 0; ch < 3; ch++) begin
      expect_read(cfg_addr(ch, 1'b0), cfg_model[ch].half.lo,
                  $sformatf("data_o (cfg%0d lo)", ch));
      expect_read(cfg_addr(ch, 1'b1), cfg_model[ch].half.hi,
                  $sformatf("data_o (cfg%0d hi)", ch));
    end
  endtask

  task automatic run_samples(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge ck933);
      for (int ch = 0; ch < 3; ch++) begin
        rng        = xorshift32(rng);
        smp[ch]    = rng[17:0];
        smp_en[ch] = rng[23];                   // roughly half the cycles
      end
    end
    @(negedge ck933);
    smp_en = '0;
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rs !== 1'b0) begin
      if (n == wait_limit) begin
        fail_run("timed out waiting for the external reset to release");
      end
      @(posedge ck933);
      n++;
    end
  endtask

  task automatic wait_dac_rst(input logic level, input string what);
    int n;
    n = 0;
    while (dac_rst !== level) begin
      if (n == wait_limit) begin
        fail_run($sformatf("timed out waiting for dac_rst_o to %s", what));
      end
      @(negedge ck933);
      n++;
    end
  endtask

  //**************************************************************************
  // test sequence
  //**************************************************************************

  initial begin
    ncs          = 1'b1;
    nwe          = 1'b1;
    nrd          = 1'b1;
    addr         = '0;
    data_in      = '0;
    smp_en       = '0;
    smp          = '0;
    model_clear  = 1'b0;
    dac_check_on = 1'b0;
    rng          = 32'hd98a779f;
    for (int ch = 0; ch < 3; ch++) begin
      cfg_model[ch] = '0;
    end
    wait_reset_release();

    // state after reset
    expect_read(`MISC_VERSION, `TRELLIS_VERSION, "data_o (version)");
    check_cfg_all();
    expect_read(12'h500, 16'h0000, "data_o (unmapped space)");
    expect_read(12'h008, 16'h0000, "data_o (unmapped misc offset)");
    @(posedge ck933);
    check_flag("data_oe_o", data_oe, 1'b0);     // bus idle
    check_dac_midscale();
    dac_check_on = 1'b1;

    // register halves, each write must leave the other channels alone
    for (int ch = 0; ch < 3; ch++) begin
      rng = xorshift32(rng);
      cfg_write(ch, 1'b0, rng[15:0]);
      cfg_write(ch, 1'b1, rng[31:16]);
      check_cfg_all();
    end

    // enable only, hi half is don't care here
    for (int ch = 0; ch < 3; ch++) begin
      cfg_write(ch, 1'b1, 16'h3abc);
      cfg_write(ch, 1'b0, 16'h0001);
    end
    run_samples(200);

    // force wins over enable, ch1 disabled
    cfg_write(0, 1'b1, 16'h1a5c);
    cfg_write(0, 1'b0, 16'h0003);
    cfg_write(1, 1'b0, 16'h0000);
    cfg_write(2, 1'b1, 16'h3fff);
    cfg_write(2, 1'b0, 16'h0002);
    run_samples(60);
    @(negedge ck933);
    smp_en = 3'b111;
    @(negedge ck933);
    smp_en = '0;
    check_code("dac0_d_o", dac_d[0], 14'h1a5c);
    check_code("dac1_d_o", dac_d[1], `DAC_MIDSCALE);
    check_code("dac2_d_o", dac_d[2], 14'h3fff);

    // software reset through the misc space
    dac_check_on = 1'b0;
    model_clear  = 1'b1;
    bus_write(`MISC_RESET, 16'h0001);
    wait_dac_rst(1'b1, "rise");
    wait_dac_rst(1'b0, "fall");
    for (int ch = 0; ch < 3; ch++) begin
      cfg_model[ch] = '0;
    end
    model_clear = 1'b0;
    check_dac_midscale();
    dac_check_on = 1'b1;
    check_cfg_all();
    expect_read(`MISC_VERSION, `TRELLIS_VERSION, "data_o (version)");
    run_samples(20);                            // disabled channels stay mid-scale

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+src
src/trellis_pkg.sv
src/trellis_bus_decode.sv
src/trellis_reset_gen.sv
src/trellis_dac_channel.sv
src/trellis_read_mux.sv
src/trellis_top.sv
verif/trellis_clk_gen.sv
verif/trellis_tb.sv

// File: Bender.yml
package:
  name: trellis

sources:
  - include_dirs:
      - src
    files:
      - src/trellis_pkg.sv
      - src/trellis_bus_decode.sv
      - src/trellis_reset_gen.sv
      - src/trellis_dac_channel.sv
      - src/trellis_read_mux.sv
      - src/trellis_top.sv
      - target: test
        files:
          - verif/trellis_clk_gen.sv
          - verif/trellis_tb.sv
